// File: common/ks_out_params.svh
`ifndef KS_OUT_PARAMS_SVH
`define KS_OUT_PARAMS_SVH

// ----------------------------------------------------------
// Key-switch output stage sizes
// ----------------------------------------------------------

// Column lanes fed by the key-switch multiplier
`define KS_LBX 2

// Batches in flight
`define KS_BATCH_NB 2

// Product width, and LWE coefficient width (log2 of 2N)
`define KS_OP_W 16
`define KS_COEF_W 8

// Mask columns; the body sits at column KS_LWE_K
`define KS_LWE_K 4

// Columns visited by one lane per loop
`define KS_BLOCK_COL_NB 3

// FIFO depths
`define KS_XFIFO_DEPTH 2
`define KS_LFIFO_DEPTH 8
`define KS_BODY_DEPTH 2

`endif

// File: common/ks_out_pkg.sv
`include "ks_out_params.svh"

package ks_out_pkg;

  // ----------------------------------------------------------
  // Derived widths
  // ----------------------------------------------------------
  localparam int BATCH_W = (`KS_BATCH_NB > 1) ? $clog2(`KS_BATCH_NB) : 1;
  localparam int COL_W   = $clog2(`KS_LBX * `KS_BLOCK_COL_NB);
  localparam int BLK_W   = (`KS_BLOCK_COL_NB > 1) ? $clog2(`KS_BLOCK_COL_NB) : 1;
  localparam int LANE_W  = (`KS_LBX > 1) ? $clog2(`KS_LBX) : 1;

  // ----------------------------------------------------------
  // Shared types
  // ----------------------------------------------------------

  // One product from the multiplier
  typedef struct packed {
    logic               avail;
    logic               last_pbs;
    logic [BATCH_W-1:0] batch_id;
    logic [`KS_OP_W-1:0] data;
  } mult_in_t;

  // Mask coefficient on its way to the ordering FIFO
  typedef struct packed {
    logic [`KS_BATCH_NB-1:0] batch_1h;
    logic                    last_pbs;
    logic                    last_mask;
    logic [`KS_COEF_W-1:0]   coef;
  } xdata_t;

  // Body RAM write
  typedef struct packed {
    logic [`KS_COEF_W-1:0] coef;
    logic                  parity;
  } body_wr_t;

endpackage

// File: ks_col_lane/ks_col_lane.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_col_lane #(
  parameter int LANE_ID = 0
) (
  input  logic                                   clk,
  input  logic                                   s_rst_n,
  input  ks_out_pkg::mult_in_t                   mult_i,
  input  logic                                   reset_loop_i,
  input  logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0]  body_i,
  input  logic [`KS_BATCH_NB-1:0]                body_vld_i,
  input  logic [`KS_BATCH_NB-1:0]                x_rdy_i,
  output logic [`KS_BATCH_NB-1:0]                body_take_o,
  output logic [`KS_BATCH_NB-1:0]                body_wr_en_o,
  output ks_out_pkg::body_wr_t                   body_wr_o,
  output logic [`KS_BATCH_NB-1:0]                ksk_done_o,
  output ks_out_pkg::xdata_t                     x_o,
  output logic [`KS_BATCH_NB-1:0]                x_vld_o
);

  localparam int BATCH_W = ks_out_pkg::BATCH_W;
  localparam int COL_W   = ks_out_pkg::COL_W;
  localparam int BLK_W   = ks_out_pkg::BLK_W;
  localparam int OP_W    = `KS_OP_W;
  localparam int COEF_W  = `KS_COEF_W;

  // ----------------------------------------------------------
  // Column counters, one set per batch
  // ----------------------------------------------------------
  logic [`KS_BATCH_NB-1:0][BLK_W-1:0] col_q;
  logic [`KS_BATCH_NB-1:0][COL_W-1:0] x_q;
  logic [`KS_BATCH_NB-1:0]            parity_q;
  logic                               col_done;

  assign col_done = mult_i.avail & mult_i.last_pbs;

  always_ff @(posedge clk) begin
    if (!s_rst_n || reset_loop_i) begin
      for (int b = 0; b < `KS_BATCH_NB; b++) begin
        col_q[b]    <= '0;
        x_q[b]      <= COL_W'(LANE_ID);
        parity_q[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < `KS_BATCH_NB; b++) begin
        if (col_done && mult_i.batch_id == BATCH_W'(b)) begin
          if (col_q[b] == BLK_W'(`KS_BLOCK_COL_NB - 1)) begin
            // Loop wrap
            col_q[b]    <= '0;
            x_q[b]      <= COL_W'(LANE_ID);
            parity_q[b] <= ~parity_q[b];
          end else begin
            col_q[b] <= col_q[b] + 1'b1;
            x_q[b]   <= x_q[b] + COL_W'(`KS_LBX);
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // s0 : column decode and subtraction
  // ----------------------------------------------------------
  logic [COL_W-1:0] s0_cur_x;
  logic             s0_is_body;
  logic             s0_last_mask;
  logic             s0_keep;
  logic [OP_W-1:0]  s0_coef;

  assign s0_cur_x     = x_q[mult_i.batch_id];
  assign s0_is_body   = (s0_cur_x == COL_W'(`KS_LWE_K));
  assign s0_last_mask = (s0_cur_x == COL_W'(`KS_LWE_K - 1));
  // Extra columns dumped, body results need a body word
  assign s0_keep      = (s0_cur_x <= COL_W'(`KS_LWE_K)) &
                        (~s0_is_body | body_vld_i[mult_i.batch_id]);
  assign s0_coef      = (s0_is_body ? body_i[mult_i.batch_id] : '0) - mult_i.data;

  always_comb begin
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      body_take_o[b] = mult_i.avail & s0_is_body & (mult_i.batch_id == BATCH_W'(b));
    end
  end

  // ----------------------------------------------------------
  // s1 : mod switch to 2N with rounding
  // ----------------------------------------------------------
  logic               s1_avail;
  logic [OP_W-1:0]    s1_coef;
  logic               s1_last_pbs;
  logic               s1_last_mask;
  logic               s1_is_body;
  logic               s1_parity;
  logic [BATCH_W-1:0] s1_batch;
  logic [COEF_W-1:0]  s1_mdsw;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_avail   <= 1'b0;
      ksk_done_o <= '0;
    end else begin
      s1_avail <= mult_i.avail & s0_keep;
      for (int b = 0; b < `KS_BATCH_NB; b++) begin
        ksk_done_o[b] <= col_done & (mult_i.batch_id == BATCH_W'(b));
      end
    end
  end

  always_ff @(posedge clk) begin
    s1_coef      <= s0_coef;
    s1_last_pbs  <= mult_i.last_pbs;
    s1_last_mask <= s0_last_mask;
    s1_is_body   <= s0_is_body;
    s1_parity    <= parity_q[mult_i.batch_id];
    s1_batch     <= mult_i.batch_id;
  end

  // Top bits plus the first dropped bit, wraps modulo 2N
  assign s1_mdsw = s1_coef[OP_W-1 -: COEF_W] + COEF_W'(s1_coef[OP_W-1-COEF_W]);

  // ----------------------------------------------------------
  // s2 : pipe, then body write register
  // ----------------------------------------------------------
  logic               s2_mask_avail;
  logic               s2_body_avail;
  logic [COEF_W-1:0]  s2_mdsw;
  logic               s2_last_pbs;
  logic               s2_last_mask;
  logic               s2_parity;
  logic [BATCH_W-1:0] s2_batch;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s2_mask_avail <= 1'b0;
      s2_body_avail <= 1'b0;
      body_wr_en_o  <= '0;
    end else begin
      s2_mask_avail <= s1_avail & ~s1_is_body;
      s2_body_avail <= s1_avail & s1_is_body;
      for (int b = 0; b < `KS_BATCH_NB; b++) begin
        body_wr_en_o[b] <= s2_body_avail & (s2_batch == BATCH_W'(b));
      end
    end
  end

  always_ff @(posedge clk) begin
    s2_mdsw          <= s1_mdsw;
    s2_last_pbs      <= s1_last_pbs;
    s2_last_mask     <= s1_last_mask;
    s2_parity        <= s1_parity;
    s2_batch         <= s1_batch;
    body_wr_o.coef   <= s2_mdsw;
    body_wr_o.parity <= s2_parity;
  end

  // ----------------------------------------------------------
  // Lane FIFO for mask coefficients
  // ----------------------------------------------------------
  ks_out_pkg::xdata_t xf_in;
  logic               xf_in_rdy;
  logic               xf_out_vld;
  logic               xf_out_rdy;

  always_comb begin
    xf_in.last_pbs  = s2_last_pbs;
    xf_in.last_mask = s2_last_mask;
    xf_in.coef      = s2_mdsw;
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      xf_in.batch_1h[b] = (s2_batch == BATCH_W'(b));
    end
  end

  sync_fifo #(
    .WIDTH ($bits(ks_out_pkg::xdata_t)),
    .DEPTH (`KS_XFIFO_DEPTH)
  ) u_xfifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (xf_in),
    .in_vld_i   (s2_mask_avail),
    .in_rdy_o   (xf_in_rdy),
    .out_data_o (x_o),
    .out_vld_o  (xf_out_vld),
    .out_rdy_i  (xf_out_rdy)
  );

  // Route to the ordering FIFO of the item's batch
  assign x_vld_o    = {`KS_BATCH_NB{xf_out_vld}} & x_o.batch_1h;
  assign xf_out_rdy = |(x_rdy_i & x_o.batch_1h);

endmodule

// File: source/ks_body_path.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_body_path (
  input  logic                                  clk,
  input  logic                                  s_rst_n,
  input  logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0] body_data_i,
  input  logic [`KS_BATCH_NB-1:0]               body_vld_i,
  output logic [`KS_BATCH_NB-1:0]               body_rdy_o,
  input  logic                                  reset_cache_i,
  output logic                                  reset_loop_o,
  input  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]  body_take_i,
  output logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0] body_o,
  output logic [`KS_BATCH_NB-1:0]               body_vld_o,
  input  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]  lane_wr_en_i,
  input  ks_out_pkg::body_wr_t [`KS_LBX-1:0]    lane_wr_i,
  output logic [`KS_BATCH_NB-1:0]               body_wr_en_o,
  output ks_out_pkg::body_wr_t [`KS_BATCH_NB-1:0] body_wr_o
);

  logic [`KS_BATCH_NB-1:0]                    body_out_rdy;
  logic [`KS_BATCH_NB-1:0]                    wr_en_d;
  ks_out_pkg::body_wr_t [`KS_BATCH_NB-1:0]    wr_d;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      reset_loop_o <= 1'b0;
    end else begin
      reset_loop_o <= reset_cache_i;
    end
  end

  // ----------------------------------------------------------
  // Body input FIFOs
  // ----------------------------------------------------------
  // A lane take pops the word, a cache reset drains it
  always_comb begin
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      body_out_rdy[b] = reset_loop_o;
      for (int l = 0; l < `KS_LBX; l++) begin
        body_out_rdy[b] = body_out_rdy[b] | body_take_i[l][b];
      end
    end
  end

  for (genvar gb = 0; gb < `KS_BATCH_NB; gb++) begin : gen_bfifo
    sync_fifo #(
      .WIDTH (`KS_OP_W),
      .DEPTH (`KS_BODY_DEPTH)
    ) u_bfifo (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .in_data_i  (body_data_i[gb]),
      .in_vld_i   (body_vld_i[gb]),
      .in_rdy_o   (body_rdy_o[gb]),
      .out_data_o (body_o[gb]),
      .out_vld_o  (body_vld_o[gb]),
      .out_rdy_i  (body_out_rdy[gb])
    );
  end

  // ----------------------------------------------------------
  // Merge of lane body writes
  // ----------------------------------------------------------
  always_comb begin
    wr_en_d = '0;
    wr_d    = '0;
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      for (int l = 0; l < `KS_LBX; l++) begin
        if (lane_wr_en_i[l][b]) begin
          wr_en_d[b] = 1'b1;
          wr_d[b]    = wr_d[b] | lane_wr_i[l];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      body_wr_en_o <= '0;
    end else begin
      body_wr_en_o <= wr_en_d;
    end
  end

  always_ff @(posedge clk) begin
    body_wr_o <= wr_d;
  end

endmodule

// File: source/ks_lwe_order.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_lwe_order (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic                                reset_loop_i,
  input  ks_out_pkg::xdata_t [`KS_LBX-1:0]    x_i,
  input  logic [`KS_LBX-1:0]                  x_vld_i,
  output logic [`KS_LBX-1:0]                  x_rdy_o,
  output logic [`KS_COEF_W-1:0]               lwe_o,
  output logic                                lwe_vld_o,
  input  logic                                lwe_rdy_i,
  output logic                                ks_loop_done_o
);

  localparam int LANE_W = ks_out_pkg::LANE_W;

  logic [LANE_W-1:0]    lane_ptr;
  ks_out_pkg::xdata_t   sel_x;
  logic                 sel_vld;
  logic                 last_lane;
  logic                 grp_end;
  logic                 lf_in_rdy;
  logic                 wr_en;
  logic                 lf_out_done;
  logic                 lf_out_rdy;

  // ----------------------------------------------------------
  // Lane selection, all PBS of one lane before the next
  // ----------------------------------------------------------
  assign sel_x     = x_i[lane_ptr];
  assign sel_vld   = x_vld_i[lane_ptr];
  assign last_lane = (lane_ptr == LANE_W'(`KS_LBX - 1));
  assign grp_end   = sel_x.last_pbs & (last_lane | sel_x.last_mask);
  assign wr_en     = sel_vld & lf_in_rdy;

  always_comb begin
    for (int l = 0; l < `KS_LBX; l++) begin
      x_rdy_o[l] = (lane_ptr == LANE_W'(l)) & lf_in_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n || reset_loop_i) begin
      lane_ptr <= '0;
    end else if (wr_en && sel_x.last_pbs) begin
      lane_ptr <= (last_lane || sel_x.last_mask) ? '0 : lane_ptr + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Ordering FIFO, coef stored with its end-of-group flag
  // ----------------------------------------------------------
  sync_fifo #(
    .WIDTH (`KS_COEF_W + 1),
    .DEPTH (`KS_LFIFO_DEPTH)
  ) u_lfifo (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  ({grp_end, sel_x.coef}),
    .in_vld_i   (sel_vld),
    .in_rdy_o   (lf_in_rdy),
    .out_data_o ({lf_out_done, lwe_o}),
    .out_vld_o  (lwe_vld_o),
    .out_rdy_i  (lf_out_rdy)
  );

  // Forced ready while the cache resets
  assign lf_out_rdy = lwe_rdy_i | reset_loop_i;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ks_loop_done_o <= 1'b0;
    end else begin
      ks_loop_done_o <= lwe_vld_o & lf_out_rdy & lf_out_done;
    end
  end

endmodule

// File: source/ks_out_top.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_out_top (
  input  logic                                    clk,
  input  logic                                    s_rst_n,
  input  ks_out_pkg::mult_in_t [`KS_LBX-1:0]      mult_i,
  input  logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0]   body_data_i,
  input  logic [`KS_BATCH_NB-1:0]                 body_vld_i,
  output logic [`KS_BATCH_NB-1:0]                 body_rdy_o,
  output logic [`KS_BATCH_NB-1:0][`KS_COEF_W-1:0] lwe_o,
  output logic [`KS_BATCH_NB-1:0]                 lwe_vld_o,
  input  logic [`KS_BATCH_NB-1:0]                 lwe_rdy_i,
  output logic [`KS_BATCH_NB-1:0]                 body_wr_en_o,
  output ks_out_pkg::body_wr_t [`KS_BATCH_NB-1:0] body_wr_o,
  input  logic                                    reset_cache_i,
  output logic [`KS_BATCH_NB-1:0]                 ks_loop_done_o,
  output logic [`KS_BATCH_NB-1:0]                 inc_ksk_rd_ptr_o
);

  ks_out_pkg::mult_in_t [`KS_LBX-1:0]      s0_mult;
  logic                                    reset_loop;
  logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0]   body;
  logic [`KS_BATCH_NB-1:0]                 body_vld;
  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]    body_take;
  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]    lane_wr_en;
  ks_out_pkg::body_wr_t [`KS_LBX-1:0]      lane_wr;
  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]    ksk_done;
  ks_out_pkg::xdata_t [`KS_LBX-1:0]        lane_x;
  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]    lane_x_vld;
  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0]    lane_x_rdy;
  logic [`KS_BATCH_NB-1:0][`KS_LBX-1:0]    ord_x_vld;
  logic [`KS_BATCH_NB-1:0][`KS_LBX-1:0]    ord_x_rdy;

  // Read pointer moves when the last lane closes a column
  assign inc_ksk_rd_ptr_o = ksk_done[`KS_LBX-1];

  // ----------------------------------------------------------
  // Column lanes with their input register
  // ----------------------------------------------------------
  for (genvar gl = 0; gl < `KS_LBX; gl++) begin : gen_lane
    always_ff @(posedge clk) begin
      if (!s_rst_n) begin
        s0_mult[gl].avail <= 1'b0;
      end else begin
        s0_mult[gl] <= mult_i[gl];
      end
    end

    ks_col_lane #(
      .LANE_ID (gl)
    ) u_lane (
      .clk          (clk),
      .s_rst_n      (s_rst_n),
      .mult_i       (s0_mult[gl]),
      .reset_loop_i (reset_loop),
      .body_i       (body),
      .body_vld_i   (body_vld),
      .x_rdy_i      (lane_x_rdy[gl]),
      .body_take_o  (body_take[gl]),
      .body_wr_en_o (lane_wr_en[gl]),
      .body_wr_o    (lane_wr[gl]),
      .ksk_done_o   (ksk_done[gl]),
      .x_o          (lane_x[gl]),
      .x_vld_o      (lane_x_vld[gl])
    );
  end

  ks_body_path u_body_path (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .body_data_i   (body_data_i),
    .body_vld_i    (body_vld_i),
    .body_rdy_o    (body_rdy_o),
    .reset_cache_i (reset_cache_i),
    .reset_loop_o  (reset_loop),
    .body_take_i   (body_take),
    .body_o        (body),
    .body_vld_o    (body_vld),
    .lane_wr_en_i  (lane_wr_en),
    .lane_wr_i     (lane_wr),
    .body_wr_en_o  (body_wr_en_o),
    .body_wr_o     (body_wr_o)
  );

  // ----------------------------------------------------------
  // Per-batch ordering
  // ----------------------------------------------------------
  for (genvar gb = 0; gb < `KS_BATCH_NB; gb++) begin : gen_order
    for (genvar gl = 0; gl < `KS_LBX; gl++) begin : gen_xpose
      assign ord_x_vld[gb][gl]  = lane_x_vld[gl][gb];
      assign lane_x_rdy[gl][gb] = ord_x_rdy[gb][gl];
    end

    ks_lwe_order u_order (
      .clk            (clk),
      .s_rst_n        (s_rst_n),
      .reset_loop_i   (reset_loop),
      .x_i            (lane_x),
      .x_vld_i        (ord_x_vld[gb]),
      .x_rdy_o        (ord_x_rdy[gb]),
      .lwe_o          (lwe_o[gb]),
      .lwe_vld_o      (lwe_vld_o[gb]),
      .lwe_rdy_i      (lwe_rdy_i[gb]),
      .ks_loop_done_o (ks_loop_done_o[gb])
    );
  end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_vld_i,
  output logic             in_rdy_o,
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_vld_o,
  input  logic             out_rdy_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_nxt;
  logic             wr_en;
  logic             rd_en;

  // Full stalls the writer
  assign in_rdy_o   = (cnt != CNT_W'(DEPTH));
  assign wr_en      = in_vld_i & in_rdy_o;
  assign rd_en      = out_vld_o & out_rdy_i;
  assign out_data_o = mem[rd_ptr];

  assign cnt_nxt = cnt + CNT_W'(wr_en) - CNT_W'(rd_en);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      cnt       <= '0;
      out_vld_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      cnt       <= cnt_nxt;
      // Valid follows the next occupancy
      out_vld_o <= (cnt_nxt != '0);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

endmodule

// File: verif/ks_out_chk.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_out_chk (
  input  logic                                 clk,
  input  logic                                 s_rst_n,
  input  logic [`KS_LBX-1:0]                   xf_wr_vld_i,
  input  logic [`KS_LBX-1:0]                   xf_wr_rdy_i,
  input  logic [`KS_LBX-1:0][`KS_BATCH_NB-1:0] body_take_i,
  input  logic [`KS_BATCH_NB-1:0]              body_vld_i,
  input  logic [`KS_BATCH_NB-1:0]              body_wr_en_i
);

  // ----------------------------------------------------------
  // Lane FIFOs have no back-pressure on their write side
  // ----------------------------------------------------------
  a_xfifo_no_overflow: assert property (
    @(posedge clk) disable iff (!s_rst_n)
    (xf_wr_vld_i & ~xf_wr_rdy_i) == '0
  ) else $error("lane FIFO written while full");

  // A lane may only pop a body word that is there
  for (genvar gl = 0; gl < `KS_LBX; gl++) begin : gen_take
    a_take_with_vld: assert property (
      @(posedge clk) disable iff (!s_rst_n)
      (body_take_i[gl] & ~body_vld_i) == '0
    ) else $error("lane %0d took a body word that was not valid", gl);
  end

  // Body RAM stays untouched as reset is released
  a_no_wr_after_rst: assert property (
    @(posedge clk)
    $rose(s_rst_n) |-> (body_wr_en_i == '0)
  ) else $error("body write strobe in the first cycle after reset");

endmodule

// File: verif/ks_out_tb.sv
`timescale 1ns/100ps
`include "ks_out_params.svh"

module ks_out_tb;

  localparam int CLK_PERIOD = 10;
  localparam int STEP_NB    = 15;
  localparam int GAP_CYC    = 8;
  localparam int DRAIN_CYC  = 200;
  localparam int BATCH_W    = ks_out_pkg::BATCH_W;
  localparam int COL_W      = ks_out_pkg::COL_W;

  // One column step of one batch, every lane sends npbs products
  typedef struct packed {
    logic               rst;
    logic [BATCH_W-1:0] batch;
    logic [COL_W-1:0]   col;
    logic               parity;
    logic [1:0]         npbs;
  } step_t;

  // Fields: cache reset before the step, batch, expected column of lane 0,
  // expected body parity, PBS count
  localparam step_t STEPS [STEP_NB] = '{
    '{0, 0, 0, 0, 2}, '{0, 1, 0, 0, 1}, '{0, 0, 2, 0, 2}, '{0, 1, 2, 0, 1},
    '{0, 0, 4, 0, 2}, '{0, 1, 4, 0, 1},
    '{0, 0, 0, 1, 2}, '{0, 1, 0, 1, 1}, '{0, 0, 2, 1, 2}, '{0, 1, 2, 1, 1},
    '{0, 0, 4, 1, 2},
    // Batch 1 stopped mid loop, restarts at column 0 and parity 0
    '{1, 1, 0, 0, 1}, '{0, 0, 0, 0, 2}, '{0, 1, 2, 0, 1}, '{0, 1, 4, 0, 1}
  };

  logic                                    clk = 1'b0;
  logic                                    s_rst_n;
  ks_out_pkg::mult_in_t [`KS_LBX-1:0]      mult_i;
  logic [`KS_BATCH_NB-1:0][`KS_OP_W-1:0]   body_data_i;
  logic [`KS_BATCH_NB-1:0]                 body_vld_i;
  logic [`KS_BATCH_NB-1:0]                 body_rdy_o;
  logic [`KS_BATCH_NB-1:0][`KS_COEF_W-1:0] lwe_o;
  logic [`KS_BATCH_NB-1:0]                 lwe_vld_o;
  logic [`KS_BATCH_NB-1:0]                 lwe_rdy_i;
  logic [`KS_BATCH_NB-1:0]                 body_wr_en_o;
  ks_out_pkg::body_wr_t [`KS_BATCH_NB-1:0] body_wr_o;
  logic                                    reset_cache_i;
  logic [`KS_BATCH_NB-1:0]                 ks_loop_done_o;
  logic [`KS_BATCH_NB-1:0]                 inc_ksk_rd_ptr_o;

  // Expected outputs per batch; lwe items carry the end-of-group flag on top
  logic [`KS_COEF_W:0]  lwe_q    [`KS_BATCH_NB][$];
  ks_out_pkg::body_wr_t body_q   [`KS_BATCH_NB][$];
  time                  body_t_q [`KS_BATCH_NB][$];
  time                  ksk_t_q  [`KS_BATCH_NB][$];
  logic [`KS_BATCH_NB-1:0] done_pend  = '0;
  logic [31:0]             data_state = 32'h30ce;
  logic [31:0]             rdy_state  = 32'h30ce;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ks_out_top u_dut (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .mult_i           (mult_i),
    .body_data_i      (body_data_i),
    .body_vld_i       (body_vld_i),
    .body_rdy_o       (body_rdy_o),
    .lwe_o            (lwe_o),
    .lwe_vld_o        (lwe_vld_o),
    .lwe_rdy_i        (lwe_rdy_i),
    .body_wr_en_o     (body_wr_en_o),
    .body_wr_o        (body_wr_o),
    .reset_cache_i    (reset_cache_i),
    .ks_loop_done_o   (ks_loop_done_o),
    .inc_ksk_rd_ptr_o (inc_ksk_rd_ptr_o)
  );

  bind ks_out_top ks_out_chk u_chk (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .xf_wr_vld_i  ({gen_lane[1].u_lane.s2_mask_avail, gen_lane[0].u_lane.s2_mask_avail}),
    .xf_wr_rdy_i  ({gen_lane[1].u_lane.xf_in_rdy, gen_lane[0].u_lane.xf_in_rdy}),
    .body_take_i  (body_take),
    .body_vld_i   (body_vld),
    .body_wr_en_i (body_wr_en_o)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Round to nearest on the dropped bits, keep the top bits modulo 2N
  function automatic logic [`KS_COEF_W-1:0] mod_switch(input logic [`KS_OP_W-1:0] v);
    logic [`KS_OP_W:0] r;
    r = {1'b0, v} + (1 << (`KS_OP_W - `KS_COEF_W - 1));
    return r[`KS_OP_W-1 -: `KS_COEF_W];
  endfunction

  function automatic int pending_cnt();
    int n;
    n = 0;
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      n += lwe_q[b].size() + body_q[b].size() + ksk_t_q[b].size();
    end
    return n;
  endfunction

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic report_failure(input string msg);
    $display("At %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_cnt() != 0 && n < DRAIN_CYC) begin
      @(negedge clk);
      n++;
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus and reference model
  // ----------------------------------------------------------
  task automatic run_step(input step_t st);
    ks_out_pkg::mult_in_t m          [`KS_LBX];
    logic [`KS_OP_W-1:0]  d          [`KS_LBX];
    logic [`KS_OP_W-1:0]  body_w     [2];
    logic [`KS_COEF_W:0]  lane_items [`KS_LBX][$];
    logic                 last;
    logic                 grp_end;
    time                  t_drv;
    int                   b;
    int                   x;
    b = st.batch;
    if (st.rst) begin
      wait_drain();
      if (pending_cnt() != 0) report_failure("outputs did not drain before the cache reset");
      // Leftover body word of the stopped loop is dropped by the cache reset
      data_state = xorshift(data_state);
      @(posedge clk);
      body_vld_i[b]  <= 1'b1;
      body_data_i[b] <= data_state[`KS_OP_W-1:0];
      @(posedge clk);
      body_vld_i    <= '0;
      reset_cache_i <= 1'b1;
      @(posedge clk);
      reset_cache_i <= 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      check("lwe_vld_o", lwe_vld_o, '0);
    end
    // Body words wait in the body FIFO ahead of the body column
    if (st.col + `KS_LBX > `KS_LWE_K) begin
      for (int p = 0; p < st.npbs; p++) begin
        data_state = xorshift(data_state);
        body_w[p]  = data_state[`KS_OP_W-1:0];
        @(posedge clk);
        body_vld_i[b]  <= 1'b1;
        body_data_i[b] <= body_w[p];
        @(negedge clk);
        check("body_rdy_o", body_rdy_o[b], 1'b1);
      end
      @(posedge clk);
      body_vld_i <= '0;
    end
    for (int p = 0; p < st.npbs; p++) begin
      last = (p == st.npbs - 1);
      for (int l = 0; l < `KS_LBX; l++) begin
        data_state = xorshift(data_state);
        d[l]       = data_state[`KS_OP_W-1:0];
        m[l]       = '{avail: 1'b1, last_pbs: last, batch_id: st.batch, data: d[l]};
      end
      @(posedge clk);
      t_drv = $time;
      for (int l = 0; l < `KS_LBX; l++) begin
        mult_i[l] <= m[l];
        x = int'(st.col) + l;
        if (x == `KS_LWE_K) begin
          body_q[b].push_back('{coef: mod_switch(body_w[p] - d[l]), parity: st.parity});
          body_t_q[b].push_back(t_drv + 5 * CLK_PERIOD + CLK_PERIOD / 2);
        end else if (x < `KS_LWE_K) begin
          grp_end = last & ((l == `KS_LBX - 1) | (x == `KS_LWE_K - 1));
          lane_items[l].push_back({grp_end, mod_switch(-d[l])});
        end
      end
      if (last) begin
        ksk_t_q[b].push_back(t_drv + 2 * CLK_PERIOD + CLK_PERIOD / 2);
      end
    end
    // All PBS of lane 0, then all PBS of lane 1
    for (int l = 0; l < `KS_LBX; l++) begin
      while (lane_items[l].size() != 0) begin
        lwe_q[b].push_back(lane_items[l].pop_front());
      end
    end
    @(posedge clk);
    mult_i <= '0;
    repeat (GAP_CYC) @(posedge clk);
  endtask

  // ----------------------------------------------------------
  // Output monitors, sampled on the falling edge
  // ----------------------------------------------------------
  task automatic check_lwe(input int b);
    logic [`KS_COEF_W:0] e;
    check("ks_loop_done_o", ks_loop_done_o[b], done_pend[b]);
    done_pend[b] = 1'b0;
    if (lwe_vld_o[b] && lwe_rdy_i[b]) begin
      if (lwe_q[b].size() == 0) begin
        report_failure($sformatf("batch %0d sent a coefficient that was not expected", b));
      end else begin
        e = lwe_q[b].pop_front();
        check("lwe_o", lwe_o[b], e[`KS_COEF_W-1:0]);
        done_pend[b] = e[`KS_COEF_W];
      end
    end
  endtask

  task automatic check_body(input int b);
    ks_out_pkg::body_wr_t e;
    if (body_wr_en_o[b]) begin
      if (body_q[b].size() == 0) begin
        report_failure($sformatf("batch %0d wrote the body RAM without a body column", b));
      end else begin
        e = body_q[b].pop_front();
        check("body_wr_en_o time", $time, body_t_q[b].pop_front());
        check("body_wr_o.coef", body_wr_o[b].coef, e.coef);
        check("body_wr_o.parity", body_wr_o[b].parity, e.parity);
      end
    end
  endtask

  task automatic check_ksk(input int b);
    if (inc_ksk_rd_ptr_o[b]) begin
      if (ksk_t_q[b].size() == 0) begin
        report_failure($sformatf("batch %0d moved the key read pointer unexpectedly", b));
      end else begin
        check("inc_ksk_rd_ptr_o time", $time, ksk_t_q[b].pop_front());
      end
    end
  endtask

  always @(negedge clk) begin
    if (s_rst_n) begin
      for (int b = 0; b < `KS_BATCH_NB; b++) begin
        check_lwe(b);
        check_body(b);
        check_ksk(b);
      end
    end
  end

  // Output ready about three cycles in four
  always @(posedge clk) begin
    rdy_state = xorshift(rdy_state);
    for (int b = 0; b < `KS_BATCH_NB; b++) begin
      lwe_rdy_i[b] <= |rdy_state[2*b +: 2];
    end
  end

  initial begin
    #(STEP_NB * 40 * CLK_PERIOD);
    $display("Watchdog expired after %0d ns without the run finishing",
             STEP_NB * 40 * CLK_PERIOD);
    stop_run();
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    s_rst_n       = 1'b0;
    mult_i        = '0;
    body_data_i   = '0;
    body_vld_i    = '0;
    lwe_rdy_i     = '0;
    reset_cache_i = 1'b0;
    repeat (3) @(posedge clk);
    s_rst_n <= 1'b1;
    @(negedge clk);
    check("lwe_vld_o", lwe_vld_o, '0);
    check("body_wr_en_o", body_wr_en_o, '0);
    check("ks_loop_done_o", ks_loop_done_o, '0);
    check("inc_ksk_rd_ptr_o", inc_ksk_rd_ptr_o, '0);
    for (int s = 0; s < STEP_NB; s++) begin
      run_step(STEPS[s]);
    end
    wait_drain();
    repeat (GAP_CYC) @(negedge clk);
    if (pending_cnt() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("%0d expected outputs never appeared", pending_cnt());
      stop_run();
    end
  end

endmodule

// File: vlog.f
+incdir+common
common/ks_out_pkg.sv
source/sync_fifo.sv
ks_col_lane/ks_col_lane.sv
source/ks_body_path.sv
source/ks_lwe_order.sv
source/ks_out_top.sv
verif/ks_out_chk.sv
verif/ks_out_tb.sv
